// ==== flist.f ====
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/addr_translate.sv
verilog/itlb.sv
verilog/fetch_fsm.sv
verilog/discard_counter.sv
verilog/fetch_top.sv
testbench/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_fetch \
        -f flist.f --Mdir obj_dir -o sim_fetch; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/sim_fetch 2>&1); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi

echo "$out"

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi

echo "pass message not found"
exit 1

// ==== testbench/tb_fetch.sv ====
`timescale 1ns/1ps
module tb_fetch import fetch_pkg::*; ();

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam logic [31:0] DATA_MASK = 32'ha5a5_0000;
    localparam int NCASE = 16;

    // redirect kinds used by the table
    localparam int K_NONE = 0;
    localparam int K_EX = 1;
    localparam int K_BRE = 2;
    localparam int K_BRD = 3;
    localparam int K_ERTN = 4;
    localparam int K_PRED = 5;
    localparam int K_MIX_EX = 6;
    localparam int K_MIX_BRD = 7;

    typedef struct {
        csr_fe_t     csr;
        int          kind;
        logic [31:0] target;
        int          tlb_idx;
        tlb_entry_t  tlb;
        int          n;
        logic [31:0] pa;
        logic [7:0]  ecode;
        logic        bp;
    } case_t;

    logic        clk;
    logic        rstn;
    csr_fe_t     csr;
    redirect_t   br_e;
    redirect_t   br_d;
    redirect_t   predict;
    redirect_t   ex_entry;
    redirect_t   ertn;
    logic        tlb_we;
    logic [2:0]  tlb_windex;
    tlb_entry_t  tlb_wentry;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    logic        fd_valid;
    fetch_out_t  fd_bus;
    logic        d_allowin;

    case_t       cases [NCASE];
    csr_fe_t     csr_da;
    csr_fe_t     csr_pg0;
    csr_fe_t     csr_pg3;
    int          cur;
    logic        armed;
    logic        redir_now;
    int          n_items;
    int          n_seen;
    int          n_req;
    int          cyc;
    int          error_count;
    logic [31:0] mem_data [$];
    int          mem_ready [$];

    fetch_top #(
        .TLBNUM      (8),
        .MAX_INFLIGHT(2),
        .RESET_PC    (RESET_PC)
    ) UUT (
        .clk(clk), .rstn(rstn), .csr(csr),
        .br_e(br_e), .br_d(br_d), .predict(predict), .ex_entry(ex_entry), .ertn(ertn),
        .tlb_we(tlb_we), .tlb_windex(tlb_windex), .tlb_wentry(tlb_wentry),
        .inst_req(inst_req), .inst_addr(inst_addr), .inst_addr_ok(inst_addr_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .fd_valid(fd_valid), .fd_bus(fd_bus), .d_allowin(d_allowin)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        error_count++;
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    // fields shown as pc/inst/ex/ecode
    task automatic check_out(input fetch_out_t got, input fetch_out_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t fd_bus got %h/%h/%b/%h exp %h/%h/%b/%h",
                     $time, got.pc, got.inst, got.ex, got.ecode,
                     exp.pc, exp.inst, exp.ex, exp.ecode);
            stop_run();
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t inst_addr got %h exp %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            $display("FAIL t=%0t %s got %0d exp %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic tlb_entry_t make_entry(input logic [18:0] vppn, input logic ps4m,
                                              input logic g, input logic [9:0] asid,
                                              input logic [19:0] ppn, input logic [1:0] plv,
                                              input logic v);
        tlb_entry_t e;
        e = '0;
        e.vppn = vppn;
        e.ps4m = ps4m;
        e.g = g;
        e.asid = asid;
        e.ppn = ppn;
        e.plv = plv;
        e.v = v;
        e.valid = 1'b1;
        return e;
    endfunction

    task automatic set_case(input int i, input csr_fe_t c, input int kind,
                            input logic [31:0] target, input int idx, input tlb_entry_t e,
                            input int n, input logic [31:0] pa, input logic [7:0] ecode,
                            input logic bp);
        cases[i] = '{c, kind, target, idx, e, n, pa, ecode, bp};
    endtask

    task automatic load_table();
        csr_da = '0;
        csr_da.da = 1'b1;
        csr_pg0 = '{asid: 10'd5, da: 1'b0, pg: 1'b1, plv: 2'd0,
                    dmw0: '{1'b1, 1'b0, 3'b101, 3'b000},
                    dmw1: '{1'b0, 1'b1, 3'b100, 3'b001}};
        csr_pg3 = csr_pg0;
        csr_pg3.plv = 2'd3;
        set_case(0, csr_da, K_NONE, RESET_PC, 0, '0, 8, RESET_PC, 8'h00, 1'b0);
        set_case(1, csr_da, K_EX, 32'h1c00_0400, 0, '0, 8, 32'h1c00_0400, 8'h00, 1'b1);
        set_case(2, csr_pg0, K_BRE, 32'ha000_1000, 0, '0, 6, 32'h0000_1000, 8'h00, 1'b0);
        set_case(3, csr_pg3, K_BRD, 32'h8000_2000, 0, '0, 6, 32'h2000_2000, 8'h00, 1'b0);
        // plv0 misses the plv3-only window and goes to the odd 4 KB page
        set_case(4, csr_pg0, K_ERTN, 32'h8000_3000, 0,
                 make_entry(19'h40001, 1'b0, 1'b0, 10'd5, 20'h12344, 2'd0, 1'b1),
                 6, 32'h1234_5000, 8'h00, 1'b1);
        set_case(5, csr_pg0, K_EX, 32'h8000_2000, 0, '0, 6, 32'h1234_4000, 8'h00, 1'b0);
        // global 4 MB page with a foreign asid
        set_case(6, csr_pg3, K_BRE, 32'h4080_0040, 1,
                 make_entry(19'h20400, 1'b1, 1'b1, 10'h3ff, 20'h30c00, 2'd3, 1'b1),
                 6, 32'h30c0_0040, 8'h00, 1'b0);
        set_case(7, csr_pg3, K_PRED, 32'h4080_0100, 0, '0, 5, 32'h30c0_0100, 8'h00, 1'b1);
        set_case(8, csr_da, K_MIX_EX, 32'h1c00_1000, 0, '0, 5, 32'h1c00_1000, 8'h00, 1'b0);
        set_case(9, csr_da, K_MIX_BRD, 32'h1c00_4000, 0, '0, 5, 32'h1c00_4000, 8'h00, 1'b0);
        set_case(10, csr_da, K_BRE, 32'h1c00_0102, 0, '0, 1, 32'h0, ECODE_ADEF, 1'b0);
        set_case(11, csr_pg0, K_BRD, 32'h6000_0000, 0, '0, 1, 32'h0, ECODE_TLBR, 1'b0);
        set_case(12, csr_pg0, K_ERTN, 32'h6000_0006, 0, '0, 1, 32'h0, ECODE_ADEF, 1'b0);
        // invalid page checked before the privilege level
        set_case(13, csr_pg3, K_EX, 32'h7000_0000, 2,
                 make_entry(19'h38000, 1'b0, 1'b0, 10'd5, 20'h00100, 2'd0, 1'b0),
                 1, 32'h0, ECODE_PIF, 1'b0);
        set_case(14, csr_pg3, K_BRE, 32'h7001_0000, 3,
                 make_entry(19'h38008, 1'b0, 1'b0, 10'd5, 20'h00200, 2'd0, 1'b1),
                 1, 32'h0, ECODE_PPI, 1'b0);
        set_case(15, csr_da, K_BRD, 32'h1c00_0800, 0, '0, 6, 32'h1c00_0800, 8'h00, 1'b1);
    endtask

    task automatic drive_redirect(input int kind, input logic [31:0] t);
        case (kind)
            K_EX:   ex_entry = '{1'b1, t};
            K_BRE:  br_e = '{1'b1, t};
            K_BRD:  br_d = '{1'b1, t};
            K_ERTN: ertn = '{1'b1, t};
            K_PRED: predict = '{1'b1, t};
            K_MIX_EX: begin
                ex_entry = '{1'b1, t};
                br_e = '{1'b1, t + 32'h1000};
                predict = '{1'b1, t + 32'h2000};
            end
            K_MIX_BRD: begin
                br_d = '{1'b1, t};
                ertn = '{1'b1, t + 32'h1000};
                predict = '{1'b1, t + 32'h2000};
            end
            default: ;
        endcase
    endtask

    task automatic wait_items();
        int t;
        t = 0;
        while (n_items < cases[cur].n) begin
            @(posedge clk);
            t++;
            if (t > 200) begin
                $display("no item reached decode within 200 cycles in case %0d", cur);
                stop_run();
            end
        end
    endtask

    // memory model, decode side and monitor
    initial begin
        fetch_out_t exp;
        int span;
        void'($urandom(32'h6594_d4dc));
        span = 0;
        forever begin
            @(negedge clk);
            if (rstn) begin
                if (inst_data_ok) begin
                    void'(mem_data.pop_front());
                    void'(mem_ready.pop_front());
                end
                if (inst_req && inst_addr_ok) begin
                    if (armed && !redir_now) begin
                        if (cases[cur].ecode != 8'h00) begin
                            $display("memory request issued in exception case %0d", cur);
                            stop_run();
                        end
                        check_addr(inst_addr, cases[cur].pa + 32'(4 * n_req));
                        n_req++;
                    end
                    mem_data.push_back(inst_addr ^ DATA_MASK);
                    mem_ready.push_back(cyc + 1 + int'($urandom % 4));
                end
                if (fd_valid && d_allowin && armed && !redir_now) begin
                    n_seen++;
                    if (n_items < cases[cur].n) begin
                        if (cases[cur].ecode != 8'h00) begin
                            exp = '{cases[cur].target, 32'h0, 1'b1, cases[cur].ecode};
                        end else begin
                            exp.pc = cases[cur].target + 32'(4 * n_items);
                            exp.inst = (cases[cur].pa + 32'(4 * n_items)) ^ DATA_MASK;
                            exp.ex = 1'b0;
                            exp.ecode = 8'h00;
                        end
                        check_out(fd_bus, exp);
                        n_items++;
                    end
                end
            end
            @(posedge clk);
            #1;
            cyc++;
            inst_data_ok = (mem_ready.size() > 0) && (mem_ready[0] <= cyc);
            inst_rdata = inst_data_ok ? mem_data[0] : 32'h0;
            inst_addr_ok = ($urandom % 4) != 0;
            if (span == 0) begin
                d_allowin = !cases[cur].bp || (($urandom % 2) == 0);
                span = 1 + int'($urandom % 5);
            end
            span--;
        end
    end

    initial begin
        #(NCASE * 400);
        $display("watchdog expired before the test sequence finished");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        rstn = 1'b0;
        csr = '0;
        br_e = '0;
        br_d = '0;
        predict = '0;
        ex_entry = '0;
        ertn = '0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata = '0;
        d_allowin = 1'b1;
        cyc = 0;
        error_count = 0;
        n_items = 0;
        n_seen = 0;
        n_req = 0;
        redir_now = 1'b0;
        load_table();
        cur = 0;
        csr = cases[0].csr;
        armed = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait_items();
        for (int i = 1; i < NCASE; i++) begin
            @(posedge clk);
            #1;
            armed = 1'b0;
            cur = i;
            csr = cases[i].csr;
            if (cases[i].tlb.valid) begin
                tlb_we = 1'b1;
                tlb_windex = 3'(cases[i].tlb_idx);
                tlb_wentry = cases[i].tlb;
                @(posedge clk);
                #1;
                tlb_we = 1'b0;
            end
            @(posedge clk);
            #1;
            n_items = 0;
            n_seen = 0;
            n_req = 0;
            drive_redirect(cases[i].kind, cases[i].target);
            redir_now = 1'b1;
            armed = 1'b1;
            @(posedge clk);
            #1;
            br_e = '0;
            br_d = '0;
            predict = '0;
            ex_entry = '0;
            ertn = '0;
            redir_now = 1'b0;
            wait_items();
            if (cases[i].ecode != 8'h00) begin
                // the stage must stay idle until the next redirect
                repeat (20) @(posedge clk);
                check_count(n_seen, 1, "exception items");
            end
        end
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog/addr_translate.sv ====
`timescale 1ns/1ps
module addr_translate import fetch_pkg::*; (
    input  logic [31:0] fetch_vaddr,
    input  csr_fe_t     csr,
    input  tlb_result_t tlb_res,
    output vaddr_u      lookup_va,
    output logic [9:0]  lookup_asid,
    output trans_t      trans
);

    logic        da_hit;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_path;
    logic [31:0] tlb_pa;

    function automatic logic dmw_match(input dmw_t w, input logic [1:0] plv,
                                       input logic [2:0] seg);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3);
        return plv_ok && (seg == w.vseg);
    endfunction

    assign lookup_va   = fetch_vaddr;
    assign lookup_asid = csr.asid;

    assign da_hit   = csr.da && !csr.pg;
    assign dmw0_hit = dmw_match(csr.dmw0, csr.plv, fetch_vaddr[31:29]);
    assign dmw1_hit = dmw_match(csr.dmw1, csr.plv, fetch_vaddr[31:29]);
    assign tlb_path = !da_hit && !dmw0_hit && !dmw1_hit;

    // offset width follows the page size of the hit entry
    assign tlb_pa = tlb_res.ps4m ? {tlb_res.ppn[19:10], lookup_va.p4m.offset}
                                 : {tlb_res.ppn, lookup_va.p4k.offset};

    always_comb begin
        if (da_hit) begin
            trans.paddr = fetch_vaddr;
        end else if (dmw0_hit) begin
            trans.paddr = {csr.dmw0.pseg, fetch_vaddr[28:0]};
        end else if (dmw1_hit) begin
            trans.paddr = {csr.dmw1.pseg, fetch_vaddr[28:0]};
        end else begin
            trans.paddr = tlb_pa;
        end
    end

    always_comb begin
        trans.ex    = 1'b1;
        trans.ecode = 8'h00;
        if (fetch_vaddr[1:0] != 2'b00) begin
            trans.ecode = ECODE_ADEF;
        end else if (tlb_path && !tlb_res.found) begin
            trans.ecode = ECODE_TLBR;
        end else if (tlb_path && !tlb_res.v) begin
            trans.ecode = ECODE_PIF;
        end else if (tlb_path && (csr.plv > tlb_res.plv)) begin
            trans.ecode = ECODE_PPI;
        end else begin
            trans.ex = 1'b0;
        end
    end

endmodule

// ==== verilog/discard_counter.sv ====
`timescale 1ns/1ps
module discard_counter #(
    parameter int MAX_INFLIGHT = 2
) (
    input  logic clk,
    input  logic rstn,
    input  logic accept,
    input  logic reply,
    input  logic flush,
    output logic full,
    output logic drop_reply
);

    localparam int CW = $clog2(MAX_INFLIGHT + 1);

    logic [CW-1:0] out_cnt;
    logic [CW-1:0] out_nx;
    logic [CW-1:0] stale_cnt;

    assign out_nx     = out_cnt + CW'(accept) - CW'(reply);
    assign full       = (out_cnt == CW'(MAX_INFLIGHT));
    assign drop_reply = (stale_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_cnt   <= '0;
            stale_cnt <= '0;
        end else begin
            out_cnt <= out_nx;
            // everything still on the bus after a flush is stale
            if (flush) begin
                stale_cnt <= out_nx;
            end else if (reply && drop_reply) begin
                stale_cnt <= stale_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/fetch_fsm.sv ====
`timescale 1ns/1ps
module fetch_fsm import fetch_pkg::*; #(
    parameter int MAX_INFLIGHT = 2
) (
    input  logic        clk,
    input  logic        rstn,
    input  trans_t      trans,
    input  logic [31:0] fetch_vaddr,
    input  logic        redirect_taken,
    input  logic        full,
    input  logic        drop_reply,
    output logic        advance,
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic        inst_addr_ok,
    input  logic        inst_data_ok,
    input  logic [31:0] inst_rdata,
    output logic        fd_valid,
    output fetch_out_t  fd_bus,
    input  logic        d_allowin
);

    localparam int PW = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CW = $clog2(MAX_INFLIGHT + 1);

    typedef enum logic [1:0] {FETCH, HOLD, EXC_WAIT} state_e;

    state_e        state;
    state_e        state_nx;
    logic          run;
    logic          exc_held;
    fetch_out_t    exc_item;
    logic [31:0]   q_pc   [MAX_INFLIGHT];
    logic [31:0]   q_inst [MAX_INFLIGHT];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] fill_ptr;
    logic [CW-1:0] q_cnt;
    logic [CW-1:0] n_ready;
    logic [CW-1:0] q_cnt_nx;
    logic [CW-1:0] n_ready_nx;
    logic          reply_ok;
    logic          start_exc;
    logic          push;
    logic          fill;
    logic          pop;

    function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
        if (p == PW'(MAX_INFLIGHT - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign reply_ok  = inst_data_ok && !drop_reply;
    assign inst_req  = run && (state == FETCH) && !full && !trans.ex;
    assign inst_addr = trans.paddr;
    assign advance   = inst_req && inst_addr_ok;
    // exception item waits until every older request has drained
    assign start_exc = run && (state == FETCH) && trans.ex && (q_cnt == '0);

    assign push = advance && !redirect_taken;
    assign fill = reply_ok && !redirect_taken;
    assign fd_valid = !redirect_taken && (exc_held || n_ready != '0 || reply_ok);
    assign pop  = fd_valid && d_allowin && !exc_held;

    assign q_cnt_nx   = q_cnt + CW'(push) - CW'(pop);
    assign n_ready_nx = n_ready + CW'(fill) - CW'(pop);

    always_comb begin
        if (exc_held) begin
            fd_bus = exc_item;
        end else begin
            fd_bus.pc    = q_pc[rd_ptr];
            // reply goes straight through when nothing older waits
            fd_bus.inst  = (n_ready != '0) ? q_inst[rd_ptr] : inst_rdata;
            fd_bus.ex    = 1'b0;
            fd_bus.ecode = 8'h00;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            FETCH: begin
                if (!redirect_taken && (start_exc || n_ready_nx != '0)) begin
                    state_nx = HOLD;
                end
            end
            HOLD: begin
                if (redirect_taken) begin
                    state_nx = FETCH;
                end else if (exc_held) begin
                    if (d_allowin) begin
                        state_nx = EXC_WAIT;
                    end
                end else if (n_ready_nx == '0) begin
                    state_nx = FETCH;
                end
            end
            default: begin
                if (redirect_taken) begin
                    state_nx = FETCH;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= FETCH;
            run      <= 1'b0;
            exc_held <= 1'b0;
        end else begin
            state    <= state_nx;
            run      <= 1'b1;
            exc_held <= (state_nx == HOLD) && (exc_held || start_exc);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || redirect_taken) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            fill_ptr <= '0;
            q_cnt    <= '0;
            n_ready  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (fill) begin
                fill_ptr <= bump(fill_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            q_cnt   <= q_cnt_nx;
            n_ready <= n_ready_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[wr_ptr] <= fetch_vaddr;
        end
        if (fill) begin
            q_inst[fill_ptr] <= inst_rdata;
        end
        if (start_exc) begin
            exc_item <= '{pc: fetch_vaddr, inst: 32'h0, ex: 1'b1, ecode: trans.ecode};
        end
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // 4 KB page view of a virtual address
    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] offset;
    } va_4k_t;

    // 4 MB page view
    typedef struct packed {
        logic [9:0]  vpn;
        logic [21:0] offset;
    } va_4m_t;

    typedef union packed {
        va_4k_t p4k;
        va_4m_t p4m;
    } vaddr_u;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic [9:0] asid;
        logic       da;
        logic       pg;
        logic [1:0] plv;
        dmw_t       dmw0;
        dmw_t       dmw1;
    } csr_fe_t;

    // ps4m set selects a 4 MB page
    typedef struct packed {
        logic [18:0] vppn;
        logic        ps4m;
        logic        g;
        logic [9:0]  asid;
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
        logic        valid;
    } tlb_entry_t;

    typedef struct packed {
        logic        found;
        logic [19:0] ppn;
        logic        ps4m;
        logic [1:0]  plv;
        logic        v;
    } tlb_result_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        ex;
        logic [7:0]  ecode;
    } fetch_out_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        ex;
        logic [7:0]  ecode;
    } trans_t;

    localparam logic [7:0] ECODE_ADEF = 8'h08;
    localparam logic [7:0] ECODE_TLBR = 8'h3f;
    localparam logic [7:0] ECODE_PIF  = 8'h03;
    localparam logic [7:0] ECODE_PPI  = 8'h07;

    // source of the winning redirect
    typedef enum logic [2:0] {
        RK_NONE,
        RK_EX,
        RK_BRE,
        RK_BRD,
        RK_ERTN,
        RK_PRED
    } redir_kind_e;

endpackage

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps
module fetch_top import fetch_pkg::*; #(
    parameter int          TLBNUM       = 8,
    parameter int          MAX_INFLIGHT = 2,
    parameter logic [31:0] RESET_PC     = 32'h1c00_0000
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  csr_fe_t                   csr,
    input  redirect_t                 br_e,
    input  redirect_t                 br_d,
    input  redirect_t                 predict,
    input  redirect_t                 ex_entry,
    input  redirect_t                 ertn,
    input  logic                      tlb_we,
    input  logic [$clog2(TLBNUM)-1:0] tlb_windex,
    input  tlb_entry_t                tlb_wentry,
    output logic                      inst_req,
    output logic [31:0]               inst_addr,
    input  logic                      inst_addr_ok,
    input  logic                      inst_data_ok,
    input  logic [31:0]               inst_rdata,
    output logic                      fd_valid,
    output fetch_out_t                fd_bus,
    input  logic                      d_allowin
);

    logic [31:0] fetch_vaddr;
    logic        advance;
    logic        redirect_taken;
    logic        full;
    logic        drop_reply;
    trans_t      trans;
    tlb_result_t tlb_res;
    vaddr_u      lookup_va;
    logic [9:0]  lookup_asid;

    pc_gen #(
        .RESET_PC(RESET_PC)
    ) u_pc_gen (
        .clk           (clk),
        .rstn          (rstn),
        .br_e          (br_e),
        .br_d          (br_d),
        .predict       (predict),
        .ex_entry      (ex_entry),
        .ertn          (ertn),
        .advance       (advance),
        .fetch_vaddr   (fetch_vaddr),
        .redirect_taken(redirect_taken)
    );

    addr_translate u_addr_translate (
        .fetch_vaddr(fetch_vaddr),
        .csr        (csr),
        .tlb_res    (tlb_res),
        .lookup_va  (lookup_va),
        .lookup_asid(lookup_asid),
        .trans      (trans)
    );

    itlb #(
        .TLBNUM(TLBNUM)
    ) u_itlb (
        .clk        (clk),
        .rstn       (rstn),
        .we         (tlb_we),
        .windex     (tlb_windex),
        .wentry     (tlb_wentry),
        .lookup_va  (lookup_va),
        .lookup_asid(lookup_asid),
        .res        (tlb_res)
    );

    fetch_fsm #(
        .MAX_INFLIGHT(MAX_INFLIGHT)
    ) u_fetch_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .trans         (trans),
        .fetch_vaddr   (fetch_vaddr),
        .redirect_taken(redirect_taken),
        .full          (full),
        .drop_reply    (drop_reply),
        .advance       (advance),
        .inst_req      (inst_req),
        .inst_addr     (inst_addr),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok  (inst_data_ok),
        .inst_rdata    (inst_rdata),
        .fd_valid      (fd_valid),
        .fd_bus        (fd_bus),
        .d_allowin     (d_allowin)
    );

    // advance is exactly one accepted bus request
    discard_counter #(
        .MAX_INFLIGHT(MAX_INFLIGHT)
    ) u_discard_counter (
        .clk       (clk),
        .rstn      (rstn),
        .accept    (advance),
        .reply     (inst_data_ok),
        .flush     (redirect_taken),
        .full      (full),
        .drop_reply(drop_reply)
    );

endmodule

// ==== verilog/itlb.sv ====
`timescale 1ns/1ps
module itlb import fetch_pkg::*; #(
    parameter int TLBNUM = 8
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      we,
    input  logic [$clog2(TLBNUM)-1:0] windex,
    input  tlb_entry_t                wentry,
    input  vaddr_u                    lookup_va,
    input  logic [9:0]                lookup_asid,
    output tlb_result_t               res
);

    tlb_entry_t        tlb [TLBNUM];
    logic [TLBNUM-1:0] match;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < TLBNUM; i++) begin
                tlb[i] <= '0;
            end
        end else if (we) begin
            tlb[windex] <= wentry;
        end
    end

    always_comb begin
        logic vpn_hit;
        for (int i = 0; i < TLBNUM; i++) begin
            if (tlb[i].ps4m) begin
                vpn_hit = (tlb[i].vppn[18:9] == lookup_va.p4m.vpn);
            end else begin
                vpn_hit = (tlb[i].vppn == lookup_va.p4k.vpn[19:1]);
            end
            match[i] = tlb[i].valid && vpn_hit
                       && (tlb[i].g || tlb[i].asid == lookup_asid);
        end
    end

    // lowest matching index wins
    always_comb begin
        res = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                res.found = 1'b1;
                res.ps4m  = tlb[i].ps4m;
                res.plv   = tlb[i].plv;
                res.v     = tlb[i].v;
                // va bit 12 picks the even or odd page of the pair
                res.ppn   = tlb[i].ps4m ? tlb[i].ppn
                                        : {tlb[i].ppn[19:1], lookup_va.p4k.vpn[0]};
            end
        end
    end

endmodule

// ==== verilog/pc_gen.sv ====
`timescale 1ns/1ps
module pc_gen import fetch_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        rstn,
    input  redirect_t   br_e,
    input  redirect_t   br_d,
    input  redirect_t   predict,
    input  redirect_t   ex_entry,
    input  redirect_t   ertn,
    input  logic        advance,
    output logic [31:0] fetch_vaddr,
    output logic        redirect_taken
);

    logic [31:0] pc;
    logic        buf_valid;
    redir_kind_e buf_kind;
    logic [31:0] buf_target;
    redir_kind_e win_kind;
    logic [31:0] win_target;
    logic        pred_blocked;

    // wrong-path prediction while a real redirect is pending
    assign pred_blocked = buf_valid && (buf_kind != RK_PRED);

    always_comb begin
        if (ex_entry.valid) begin
            win_kind = RK_EX;
        end else if (br_e.valid) begin
            win_kind = RK_BRE;
        end else if (br_d.valid) begin
            win_kind = RK_BRD;
        end else if (ertn.valid) begin
            win_kind = RK_ERTN;
        end else if (predict.valid && !pred_blocked) begin
            win_kind = RK_PRED;
        end else begin
            win_kind = RK_NONE;
        end
    end

    always_comb begin
        case (win_kind)
            RK_EX:   win_target = ex_entry.target;
            RK_BRE:  win_target = br_e.target;
            RK_BRD:  win_target = br_d.target;
            RK_ERTN: win_target = ertn.target;
            RK_PRED: win_target = predict.target;
            default: win_target = pc;
        endcase
    end

    assign redirect_taken = (win_kind != RK_NONE);

    // buffered target overrides the sequential pc until it is fetched
    assign fetch_vaddr = buf_valid ? buf_target : pc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc        <= RESET_PC;
            buf_valid <= 1'b0;
            buf_kind  <= RK_NONE;
        end else if (redirect_taken) begin
            buf_valid <= 1'b1;
            buf_kind  <= win_kind;
        end else if (advance) begin
            pc        <= fetch_vaddr + 32'd4;
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_taken) begin
            buf_target <= win_target;
        end
    end

endmodule
